//--- src/l2tlb_defs.svh
/*
  Width and depth settings shared by the L2 TLB RTL and its packages.
  L2TLB_ENTRIES must be a power of two of at least 2.
  L2TLB_MSHR_ENTRIES must be at least 2 (2 and 4 are the supported sizes).
*/
`ifndef L2TLB_DEFS_SVH
`define L2TLB_DEFS_SVH

// Sv39 virtual page number
`define L2TLB_VPN_W 27
// Physical page number
`define L2TLB_PPN_W 44
// Fully associative array size
`define L2TLB_ENTRIES 8
// In-order miss queue depth
`define L2TLB_MSHR_ENTRIES 2

`endif

//--- src/tlb_addr_pkg.sv
/*
  Address types of the L2 TLB.
  Widths follow the macros of the shared defs header.
*/
`include "l2tlb_defs.svh"

package tlb_addr_pkg;

  // Page numbers
  typedef logic [`L2TLB_VPN_W-1:0] vpn_t;
  typedef logic [`L2TLB_PPN_W-1:0] ppn_t;

  // Entry index into the translation array
  typedef logic [$clog2(`L2TLB_ENTRIES)-1:0] tlb_idx_t;

endpackage

//--- src/tlb_ctrl_pkg.sv
/*
  Control types of the L2 TLB.
  Request source tags and the two FSM encodings.
*/
package tlb_ctrl_pkg;

  // Which L1 TLB a request came from
  typedef enum logic {ITLB = 1'b0, DTLB = 1'b1} tlb_src_e;

  // Lookup FSM
  typedef enum logic [1:0] {LKP_IDLE, LKP_MISS_PUSH, LKP_ANS} lkp_state_e;

  // Page table walk FSM
  typedef enum logic [1:0] {PTW_IDLE, PTW_REQ, PTW_WAIT} ptw_state_e;

endpackage

//--- src/l2tlb_req_arbiter.sv
/*
  Holds one pending miss per L1 TLB and presents one of them.
  A source must not strobe again before its answer, so set and clear
  of the same flag never collide. The data side always wins.
*/
`timescale 1ns/1ps

module l2tlb_req_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   itlb_req_i,
  input  tlb_addr_pkg::vpn_t     itlb_vpn_i,
  input  logic                   dtlb_req_i,
  input  tlb_addr_pkg::vpn_t     dtlb_vpn_i,
  input  logic                   take_i,
  output logic                   valid_o,
  output tlb_addr_pkg::vpn_t     vpn_o,
  output tlb_ctrl_pkg::tlb_src_e src_o
);
  import tlb_addr_pkg::*;
  import tlb_ctrl_pkg::*;

  logic i_pend_q, d_pend_q;
  vpn_t i_vpn_q, d_vpn_q;

  // Pending flags, a strobe sets, a take of the presented source clears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      i_pend_q <= 1'b0;
      d_pend_q <= 1'b0;
    end else if (flush_i) begin
      i_pend_q <= 1'b0;
      d_pend_q <= 1'b0;
    end else begin
      i_pend_q <= itlb_req_i | (i_pend_q & ~(take_i & ~d_pend_q));
      d_pend_q <= dtlb_req_i | (d_pend_q & ~take_i);
    end
  end

  // Captured VPNs, only meaningful while the flag is set
  always_ff @(posedge clk_i) begin
    if (itlb_req_i) i_vpn_q <= itlb_vpn_i;
    if (dtlb_req_i) d_vpn_q <= dtlb_vpn_i;
  end

  // Fixed priority, D before I
  assign valid_o = i_pend_q | d_pend_q;
  assign src_o   = d_pend_q ? DTLB : ITLB;
  assign vpn_o   = d_pend_q ? d_vpn_q : i_vpn_q;

endmodule

//--- src/l2tlb_array.sv
/*
  Fully associative VPN to PPN store.
  Lookup is combinational over all entries. Fills go to a round-robin victim,
  with no check for an existing copy of the same VPN.
  Flush invalidates every entry and restarts the victim pointer.
*/
`timescale 1ns/1ps
`include "l2tlb_defs.svh"

module l2tlb_array (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  // Lookup port
  input  tlb_addr_pkg::vpn_t lookup_vpn_i,
  output logic               hit_o,
  output tlb_addr_pkg::ppn_t hit_ppn_o,
  // Fill port
  input  logic               fill_i,
  input  tlb_addr_pkg::vpn_t fill_vpn_i,
  input  tlb_addr_pkg::ppn_t fill_ppn_i
);
  import tlb_addr_pkg::*;

  localparam int unsigned N = `L2TLB_ENTRIES;
  localparam tlb_idx_t LAST_IDX = tlb_idx_t'(N - 1);

  logic [N-1:0] valid_q;
  vpn_t         vpn_q [N];
  ppn_t         ppn_q [N];
  tlb_idx_t     victim_q;

  // Valid bits and victim pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (flush_i) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (fill_i) begin
      valid_q[victim_q] <= 1'b1;
      // Wrap at the last entry
      if (victim_q == LAST_IDX) begin
        victim_q <= '0;
      end else begin
        victim_q <= victim_q + tlb_idx_t'(1);
      end
    end
  end

  // Translation payload
  always_ff @(posedge clk_i) begin
    if (fill_i && !flush_i) begin
      vpn_q[victim_q] <= fill_vpn_i;
      ppn_q[victim_q] <= fill_ppn_i;
    end
  end

  // Parallel compare
  // Duplicate VPNs can exist, the highest matching index wins
  always_comb begin
    hit_o     = 1'b0;
    hit_ppn_o = '0;
    for (int k = 0; k < N; k++) begin
      if (valid_q[k] && (vpn_q[k] == lookup_vpn_i)) begin
        hit_o     = 1'b1;
        hit_ppn_o = ppn_q[k];
      end
    end
  end

endmodule

//--- src/l2tlb_mshr.sv
/*
  In-order miss holding registers: a FIFO with no holes plus one waiting
  entry for the walk in flight. The waiting entry has no valid bit, each
  walk answer belongs to it by construction.
  Pushing into a full queue is not checked here, the control guards it.
*/
`timescale 1ns/1ps
`include "l2tlb_defs.svh"

module l2tlb_mshr (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clr_mshr_i,
  // Control
  input  logic                   add_entry_i,
  input  logic                   rm_entry_i,
  input  logic                   let_entry_waiting_i,
  // Status
  output logic                   req_available_o,
  output logic                   mshr_full_o,
  // Data
  input  tlb_addr_pkg::vpn_t     vpn_i,
  input  tlb_ctrl_pkg::tlb_src_e destination_i,
  output tlb_addr_pkg::vpn_t     ptw_req_vpn_o,
  output tlb_addr_pkg::vpn_t     ptw_ans_vpn_o,
  output tlb_ctrl_pkg::tlb_src_e destination_o
);
  import tlb_addr_pkg::*;
  import tlb_ctrl_pkg::*;

  localparam int unsigned N      = `L2TLB_MSHR_ENTRIES;
  localparam int unsigned LOG2_N = $clog2(N);
  localparam logic [LOG2_N-1:0] LAST_SLOT = LOG2_N'(N - 1);

  logic [LOG2_N-1:0] free_ptr_q, older_ptr_q;
  logic [N-1:0]      valid_q;
  vpn_t              vpn_q [N];
  tlb_src_e          dest_q [N];
  vpn_t              waiting_vpn_q;
  tlb_src_e          waiting_dest_q;

  // Pointers move independently, a push and a pop may share a cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      free_ptr_q  <= '0;
      older_ptr_q <= '0;
    end else if (clr_mshr_i) begin
      free_ptr_q  <= '0;
      older_ptr_q <= '0;
    end else begin
      if (add_entry_i) begin
        free_ptr_q <= (free_ptr_q == LAST_SLOT) ? '0 : free_ptr_q + 1'b1;
      end
      if (let_entry_waiting_i) begin
        older_ptr_q <= (older_ptr_q == LAST_SLOT) ? '0 : older_ptr_q + 1'b1;
      end
    end
  end

  // Slot valid bits
  // Push and pop never hit the same slot: pop needs a valid entry,
  // push needs a free one, and both pointers only meet when empty or full
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (clr_mshr_i) begin
      valid_q <= '0;
    end else begin
      if (add_entry_i) valid_q[free_ptr_q] <= 1'b1;
      if (let_entry_waiting_i) valid_q[older_ptr_q] <= 1'b0;
    end
  end

  // Slot payload
  always_ff @(posedge clk_i) begin
    if (add_entry_i) begin
      vpn_q[free_ptr_q]  <= vpn_i;
      dest_q[free_ptr_q] <= destination_i;
    end
  end

  // Waiting entry, loaded when the oldest miss goes out to the walker
  // rm_entry_i only marks the end of the walk, nothing to clear here
  always_ff @(posedge clk_i) begin
    if (let_entry_waiting_i && !rm_entry_i) begin
      waiting_vpn_q  <= vpn_q[older_ptr_q];
      waiting_dest_q <= dest_q[older_ptr_q];
    end
  end

  // Status from the valid bits
  assign mshr_full_o     = &valid_q;
  assign req_available_o = |valid_q;

  // Oldest entry feeds the walk request, waiting entry the walk answer
  assign ptw_req_vpn_o = vpn_q[older_ptr_q];
  assign ptw_ans_vpn_o = waiting_vpn_q;
  assign destination_o = waiting_dest_q;

endmodule

//--- src/l2tlb_ctrl.sv
/*
  Lookup and walk sequencing for the L2 TLB.
  A walk answer wins over a hit answer in the same cycle; the hit waits.
  A flush during a walk keeps the walk FSM waiting for that answer, which
  is then dropped, so the walker never sees two requests in flight.
*/
`timescale 1ns/1ps

module l2tlb_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   sel_valid_i,
  input  tlb_ctrl_pkg::tlb_src_e sel_src_i,
  input  logic                   hit_i,
  input  logic                   mshr_full_i,
  input  logic                   req_available_i,
  input  logic                   ptw_ans_i,
  input  tlb_ctrl_pkg::tlb_src_e waiting_dest_i,
  output logic                   sel_take_o,
  output logic                   add_entry_o,
  output logic                   rm_entry_o,
  output logic                   let_entry_waiting_o,
  output logic                   fill_o,
  output logic                   ptw_req_o,
  output logic                   itlb_ans_o,
  output logic                   dtlb_ans_o,
  output logic                   ans_from_ptw_o
);
  import tlb_ctrl_pkg::*;

  lkp_state_e lkp_state_q, lkp_state_d;
  ptw_state_e ptw_state_q, ptw_state_d;
  tlb_src_e   lkp_src_q;
  logic       ptw_drop_q;
  logic       walk_ans;
  logic       walk_pending;

  // Valid walk answer, not one left over from before a flush
  assign walk_ans     = (ptw_state_q == PTW_WAIT) && ptw_ans_i && !ptw_drop_q;
  // Walker still owes an answer after this cycle
  assign walk_pending = (ptw_state_q == PTW_REQ) || ((ptw_state_q == PTW_WAIT) && !ptw_ans_i);

  // Take only when idle and the MSHR can hold a miss
  assign sel_take_o  = (lkp_state_q == LKP_IDLE) && sel_valid_i && !mshr_full_i && !flush_i;
  assign add_entry_o = (lkp_state_q == LKP_MISS_PUSH);

  // Lookup FSM
  always_comb begin
    lkp_state_d = lkp_state_q;
    case (lkp_state_q)
      LKP_IDLE:      if (sel_take_o) lkp_state_d = hit_i ? LKP_ANS : LKP_MISS_PUSH;
      LKP_MISS_PUSH: lkp_state_d = LKP_IDLE;
      // Stalled while the walk answer uses the shared answer bus
      LKP_ANS:       if (!walk_ans) lkp_state_d = LKP_IDLE;
      default:       lkp_state_d = LKP_IDLE;
    endcase
  end

  // Walk FSM
  always_comb begin
    ptw_state_d = ptw_state_q;
    case (ptw_state_q)
      PTW_IDLE: if (req_available_i) ptw_state_d = PTW_REQ;
      PTW_REQ:  ptw_state_d = PTW_WAIT;
      PTW_WAIT: if (ptw_ans_i) ptw_state_d = PTW_IDLE;
      default:  ptw_state_d = PTW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lkp_state_q <= LKP_IDLE;
      ptw_state_q <= PTW_IDLE;
      lkp_src_q   <= ITLB;
      ptw_drop_q  <= 1'b0;
    end else if (flush_i) begin
      lkp_state_q <= LKP_IDLE;
      ptw_state_q <= walk_pending ? PTW_WAIT : PTW_IDLE;
      ptw_drop_q  <= walk_pending;
    end else begin
      lkp_state_q <= lkp_state_d;
      ptw_state_q <= ptw_state_d;
      if (sel_take_o) lkp_src_q <= sel_src_i;
      if ((ptw_state_q == PTW_WAIT) && ptw_ans_i) ptw_drop_q <= 1'b0;
    end
  end

  // Walk request and pop of the oldest miss in one cycle
  assign ptw_req_o           = (ptw_state_q == PTW_REQ);
  assign let_entry_waiting_o = ptw_req_o;

  // Walk completion
  assign fill_o         = walk_ans;
  assign rm_entry_o     = walk_ans;
  assign ans_from_ptw_o = walk_ans;

  // Answer strobes, walk result first
  assign itlb_ans_o = walk_ans ? (waiting_dest_i == ITLB)
                               : ((lkp_state_q == LKP_ANS) && (lkp_src_q == ITLB));
  assign dtlb_ans_o = walk_ans ? (waiting_dest_i == DTLB)
                               : ((lkp_state_q == LKP_ANS) && (lkp_src_q == DTLB));

endmodule

//--- src/l2tlb_top.sv
/*
  Shared L2 TLB between the L1 instruction and data TLBs.
  Each L1 source keeps at most one miss outstanding; walks are serialized.
  ans_ppn_o and ans_vpn_o are valid only while an answer strobe is high.
*/
`timescale 1ns/1ps

module l2tlb_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  // L1 requests
  input  logic               itlb_req_i,
  input  tlb_addr_pkg::vpn_t itlb_vpn_i,
  input  logic               dtlb_req_i,
  input  tlb_addr_pkg::vpn_t dtlb_vpn_i,
  // L1 answers
  output logic               itlb_ans_o,
  output logic               dtlb_ans_o,
  output tlb_addr_pkg::ppn_t ans_ppn_o,
  output tlb_addr_pkg::vpn_t ans_vpn_o,
  // Page table walker
  output logic               ptw_req_o,
  output tlb_addr_pkg::vpn_t ptw_vpn_o,
  input  logic               ptw_ans_i,
  input  tlb_addr_pkg::ppn_t ptw_ppn_i
);
  import tlb_addr_pkg::*;
  import tlb_ctrl_pkg::*;

  logic     sel_valid, sel_take, hit, fill;
  logic     add_entry, rm_entry, let_entry_waiting;
  logic     req_available, mshr_full, ans_from_ptw;
  vpn_t     sel_vpn, ptw_req_vpn, ptw_ans_vpn, lkp_vpn_q;
  ppn_t     hit_ppn, lkp_ppn_q;
  tlb_src_e sel_src, destination, lkp_src_q;

  l2tlb_req_arbiter u_arbiter (
    .clk_i, .rst_ni, .flush_i, .itlb_req_i, .itlb_vpn_i, .dtlb_req_i, .dtlb_vpn_i,
    .take_i (sel_take), .valid_o (sel_valid), .vpn_o (sel_vpn), .src_o (sel_src)
  );

  l2tlb_array u_array (
    .clk_i, .rst_ni, .flush_i,
    .lookup_vpn_i (sel_vpn), .hit_o (hit), .hit_ppn_o (hit_ppn),
    .fill_i (fill), .fill_vpn_i (ptw_ans_vpn), .fill_ppn_i (ptw_ppn_i)
  );

  // Misses are pushed one cycle after the take, from the lookup registers
  l2tlb_mshr u_mshr (
    .clk_i, .rst_ni, .clr_mshr_i (flush_i),
    .add_entry_i (add_entry), .rm_entry_i (rm_entry),
    .let_entry_waiting_i (let_entry_waiting),
    .req_available_o (req_available), .mshr_full_o (mshr_full),
    .vpn_i (lkp_vpn_q), .destination_i (lkp_src_q),
    .ptw_req_vpn_o (ptw_req_vpn), .ptw_ans_vpn_o (ptw_ans_vpn), .destination_o (destination)
  );

  l2tlb_ctrl u_ctrl (
    .clk_i, .rst_ni, .flush_i, .sel_valid_i (sel_valid), .sel_src_i (sel_src), .hit_i (hit),
    .mshr_full_i (mshr_full), .req_available_i (req_available), .ptw_ans_i,
    .waiting_dest_i (destination), .sel_take_o (sel_take), .add_entry_o (add_entry),
    .rm_entry_o (rm_entry), .let_entry_waiting_o (let_entry_waiting), .fill_o (fill),
    .ptw_req_o, .itlb_ans_o, .dtlb_ans_o, .ans_from_ptw_o (ans_from_ptw)
  );

  // Lookup result, captured on take
  always_ff @(posedge clk_i) begin
    if (sel_take) begin
      lkp_vpn_q <= sel_vpn;
      lkp_ppn_q <= hit_ppn;
      lkp_src_q <= sel_src;
    end
  end

  // Walker result bypasses the registered hit
  assign ans_ppn_o = ans_from_ptw ? ptw_ppn_i : lkp_ppn_q;
  assign ans_vpn_o = ans_from_ptw ? ptw_ans_vpn : lkp_vpn_q;
  assign ptw_vpn_o = ptw_req_vpn;

endmodule

//--- test/l2tlb_assert.sv
/*
  Strobe rules of the L2 TLB top level, attached by bind.
  Assumes the walker answers every walk request, also across a flush.
*/
`timescale 1ns/1ps

module l2tlb_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic flush_i,
  input logic itlb_ans_i,
  input logic dtlb_ans_i,
  input logic ptw_req_i,
  input logic ptw_ans_i
);

  logic walk_open_q;

  // Open from a walk request up to its answer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      walk_open_q <= 1'b0;
    end else if (ptw_req_i) begin
      walk_open_q <= 1'b1;
    end else if (ptw_ans_i) begin
      walk_open_q <= 1'b0;
    end
  end

  // Shared answer bus, one receiver per cycle
  a_one_answer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(itlb_ans_i && dtlb_ans_i))
    else $error("ITLB and DTLB answer strobes high in the same cycle");

  // Walks are serialized
  a_one_walk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ptw_req_i |-> !walk_open_q)
    else $error("Walk request issued before the previous walk was answered");

  // In-flight answers are dropped by a flush
  a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !(itlb_ans_i || dtlb_ans_i))
    else $error("Answer strobe in the cycle after a flush");

endmodule

//--- test/tb_l2tlb.sv
/*
  Table-driven testbench for the shared L2 TLB.
  The page table walker is modeled here. It answers each walk request after a
  fixed delay with the zero-extended VPN XOR a key, also across a flush.
  Each row waits for its answers, so an L1 source never has two misses out.
*/
`timescale 1ns/1ps

module tb_l2tlb;
  import tlb_addr_pkg::*;

  localparam int          WALK_LAT    = 3;
  localparam int          RST_CYCLES  = 4;
  localparam int          IDLE_CYCLES = 8;
  // Two walks ahead of a request plus take, push and answer cycles
  localparam int          WORST_LAT   = 2 * (WALK_LAT + 4) + 4;
  localparam ppn_t        PPN_KEY     = 44'hA5C_3C30_F0F1;
  localparam logic [31:0] SEED        = 32'h7a1c8e85;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic flush_i;
  logic itlb_req_i;
  logic dtlb_req_i;
  vpn_t itlb_vpn_i;
  vpn_t dtlb_vpn_i;
  logic itlb_ans_o;
  logic dtlb_ans_o;
  ppn_t ans_ppn_o;
  vpn_t ans_vpn_o;
  logic ptw_req_o;
  vpn_t ptw_vpn_o;
  logic ptw_ans_i = 1'b0;
  ppn_t ptw_ppn_i = '0;

  // Stimulus table with one entry per row in each queue
  logic row_flush[$];
  logic row_rnd[$];
  logic row_i_req[$];
  logic row_i_hit[$];
  logic row_d_req[$];
  logic row_d_hit[$];
  vpn_t row_i_vpn[$];
  vpn_t row_d_vpn[$];

  // Observed traffic updated on the rising edge
  int   i_ans_cnt = 0;
  int   d_ans_cnt = 0;
  int   walk_cnt = 0;
  ppn_t i_ans_ppn, d_ans_ppn;
  vpn_t i_ans_vpn, d_ans_vpn;
  vpn_t walk_log[$];

  // Walker model state updated on the falling edge
  int walks_served = 0;
  int walk_delay = 0;

  int cycle_cnt = 0;
  int cycle_limit;

  l2tlb_top DUT (.*);

  bind l2tlb_top l2tlb_assert u_assert (
    .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i),
    .itlb_ans_i (itlb_ans_o), .dtlb_ans_i (dtlb_ans_o),
    .ptw_req_i (ptw_req_o), .ptw_ans_i (ptw_ans_i)
  );

  always #4 clk_i = ~clk_i;

  // Run limit scales with the table length
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("TEST FAIL");
      $fatal(1, "Timeout: the run did not finish within %0d cycles", cycle_limit);
    end
  end

  // Answer and walk request monitor
  always @(posedge clk_i) begin
    if (itlb_ans_o) begin
      i_ans_cnt <= i_ans_cnt + 1;
      i_ans_ppn <= ans_ppn_o;
      i_ans_vpn <= ans_vpn_o;
    end
    if (dtlb_ans_o) begin
      d_ans_cnt <= d_ans_cnt + 1;
      d_ans_ppn <= ans_ppn_o;
      d_ans_vpn <= ans_vpn_o;
    end
    if (ptw_req_o) begin
      walk_cnt <= walk_cnt + 1;
      walk_log.push_back(ptw_vpn_o);
    end
  end

  // Walker answers the oldest unanswered request after WALK_LAT falling edges
  always @(negedge clk_i) begin
    ptw_ans_i <= 1'b0;
    if (walks_served != walk_cnt) begin
      if (walk_delay == WALK_LAT - 1) begin
        ptw_ans_i    <= 1'b1;
        ptw_ppn_i    <= walk_result(walk_log[walks_served]);
        walks_served <= walks_served + 1;
        walk_delay   <= 0;
      end else begin
        walk_delay <= walk_delay + 1;
      end
    end
  end

  function automatic ppn_t walk_result(input vpn_t vpn);
    return ppn_t'(vpn) ^ PPN_KEY;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic add_row(input logic flush, input logic rnd,
                         input logic i_req, input vpn_t i_vpn, input logic i_hit,
                         input logic d_req, input vpn_t d_vpn, input logic d_hit);
    row_flush.push_back(flush);
    row_rnd.push_back(rnd);
    row_i_req.push_back(i_req);
    row_i_vpn.push_back(i_vpn);
    row_i_hit.push_back(i_hit);
    row_d_req.push_back(d_req);
    row_d_vpn.push_back(d_vpn);
    row_d_hit.push_back(d_hit);
  endtask

  task automatic build_table();
    //      flush rnd   i_req i_vpn        i_hit d_req d_vpn        d_hit
    add_row(1'b0, 1'b0, 1'b1, 27'h0012345, 1'b0, 1'b0, 27'h0,       1'b0);
    add_row(1'b0, 1'b0, 1'b0, 27'h0,       1'b0, 1'b1, 27'h0012345, 1'b1);
    // Both cold in one cycle and D walks first
    add_row(1'b0, 1'b0, 1'b1, 27'h2000002, 1'b0, 1'b1, 27'h1000001, 1'b0);
    add_row(1'b0, 1'b0, 1'b0, 27'h0,       1'b0, 1'b1, 27'h2000002, 1'b1);
    // Flush lands while this miss is out to the walker
    add_row(1'b1, 1'b0, 1'b1, 27'h0555555, 1'b0, 1'b0, 27'h0,       1'b0);
    // Hit before the flush and now a miss that fills entry 0
    add_row(1'b0, 1'b0, 1'b1, 27'h0012345, 1'b0, 1'b0, 27'h0,       1'b0);
    // Eight more fills wrap the victim pointer onto entry 0
    add_row(1'b0, 1'b0, 1'b0, 27'h0,       1'b0, 1'b1, 27'h0300001, 1'b0);
    add_row(1'b0, 1'b0, 1'b1, 27'h0300002, 1'b0, 1'b0, 27'h0,       1'b0);
    add_row(1'b0, 1'b1, 1'b0, 27'h0,       1'b0, 1'b1, 27'h0,       1'b0);
    add_row(1'b0, 1'b0, 1'b1, 27'h0300004, 1'b0, 1'b0, 27'h0,       1'b0);
    add_row(1'b0, 1'b1, 1'b1, 27'h0,       1'b0, 1'b0, 27'h0,       1'b0);
    add_row(1'b0, 1'b0, 1'b0, 27'h0,       1'b0, 1'b1, 27'h0300006, 1'b0);
    add_row(1'b0, 1'b0, 1'b1, 27'h0300007, 1'b0, 1'b0, 27'h0,       1'b0);
    add_row(1'b0, 1'b0, 1'b0, 27'h0,       1'b0, 1'b1, 27'h0300008, 1'b0);
    // First fill was evicted while the most recent is still present
    add_row(1'b0, 1'b0, 1'b0, 27'h0,       1'b0, 1'b1, 27'h0012345, 1'b0);
    add_row(1'b0, 1'b0, 1'b1, 27'h0300008, 1'b1, 1'b0, 27'h0,       1'b0);
    add_row(1'b0, 1'b0, 1'b1, 27'h0444444, 1'b0, 1'b1, 27'h0300008, 1'b1);
  endtask

  task automatic apply_flush(input int r);
    int ans_base;
    int w_base;
    ans_base   = i_ans_cnt + d_ans_cnt;
    w_base     = walk_cnt;
    itlb_req_i = row_i_req[r];
    itlb_vpn_i = row_i_vpn[r];
    @(negedge clk_i);
    itlb_req_i = 1'b0;
    while (walk_cnt == w_base)
      @(negedge clk_i);
    // Flush sits in the cycle just before the walker answers
    repeat (WALK_LAT - 2) @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    // The walker still answers and the DUT drops that answer
    while (walks_served != walk_cnt)
      @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    check_value("answer count around flush", 64'(i_ans_cnt + d_ans_cnt), 64'(ans_base));
    check_value("ptw_req_o count around flush", 64'(walk_cnt), 64'(w_base + 1));
    check_value("ptw_vpn_o", 64'(walk_log[w_base]), 64'(row_i_vpn[r]));
  endtask

  task automatic run_row(input int r);
    vpn_t i_vpn, d_vpn;
    vpn_t exp_walks[$];
    int   i_base, d_base, w_base, need;
    i_vpn  = row_rnd[r] ? vpn_t'($urandom) : row_i_vpn[r];
    d_vpn  = row_rnd[r] ? vpn_t'($urandom) : row_d_vpn[r];
    i_base = i_ans_cnt;
    d_base = d_ans_cnt;
    w_base = walk_cnt;
    need   = int'(row_i_req[r]) + int'(row_d_req[r]);
    // Data misses go to the walker before instruction misses
    if (row_d_req[r] && !row_d_hit[r]) exp_walks.push_back(d_vpn);
    if (row_i_req[r] && !row_i_hit[r]) exp_walks.push_back(i_vpn);
    itlb_req_i = row_i_req[r];
    itlb_vpn_i = i_vpn;
    dtlb_req_i = row_d_req[r];
    dtlb_vpn_i = d_vpn;
    @(negedge clk_i);
    itlb_req_i = 1'b0;
    dtlb_req_i = 1'b0;
    while (i_ans_cnt + d_ans_cnt < i_base + d_base + need)
      @(negedge clk_i);
    // Each answer goes to the source that asked
    check_value("itlb_ans_o count", 64'(i_ans_cnt), 64'(i_base + int'(row_i_req[r])));
    check_value("dtlb_ans_o count", 64'(d_ans_cnt), 64'(d_base + int'(row_d_req[r])));
    if (row_i_req[r]) begin
      check_value("itlb ans_vpn_o", 64'(i_ans_vpn), 64'(i_vpn));
      check_value("itlb ans_ppn_o", 64'(i_ans_ppn), 64'(walk_result(i_vpn)));
    end
    if (row_d_req[r]) begin
      check_value("dtlb ans_vpn_o", 64'(d_ans_vpn), 64'(d_vpn));
      check_value("dtlb ans_ppn_o", 64'(d_ans_ppn), 64'(walk_result(d_vpn)));
    end
    check_value("ptw_req_o count", 64'(walk_cnt), 64'(w_base + exp_walks.size()));
    foreach (exp_walks[k]) begin
      check_value("ptw_vpn_o", 64'(walk_log[w_base + k]), 64'(exp_walks[k]));
    end
  endtask

  initial begin
    int ans_end;
    int walk_end;
    void'($urandom(SEED));
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    itlb_req_i = 1'b0;
    dtlb_req_i = 1'b0;
    itlb_vpn_i = '0;
    dtlb_vpn_i = '0;
    build_table();
    cycle_limit = row_flush.size() * WORST_LAT * 2 + RST_CYCLES + 2 * IDLE_CYCLES;
    repeat (RST_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    // Quiet outputs before any request
    repeat (IDLE_CYCLES) @(negedge clk_i);
    check_value("answer count after reset", 64'(i_ans_cnt + d_ans_cnt), 64'd0);
    check_value("ptw_req_o count after reset", 64'(walk_cnt), 64'd0);
    for (int r = 0; r < row_flush.size(); r++) begin
      if (row_flush[r]) begin
        apply_flush(r);
      end else begin
        run_row(r);
      end
    end
    // No stray strobes after the last answer
    ans_end  = i_ans_cnt + d_ans_cnt;
    walk_end = walk_cnt;
    repeat (IDLE_CYCLES) @(negedge clk_i);
    check_value("answer count at end", 64'(i_ans_cnt + d_ans_cnt), 64'(ans_end));
    check_value("ptw_req_o count at end", 64'(walk_cnt), 64'(walk_end));
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- sim.f
+incdir+src
src/tlb_addr_pkg.sv
src/tlb_ctrl_pkg.sv
src/l2tlb_req_arbiter.sv
src/l2tlb_array.sv
src/l2tlb_mshr.sv
src/l2tlb_ctrl.sv
src/l2tlb_top.sv
test/l2tlb_assert.sv
test/tb_l2tlb.sv

//--- run_sim.sh
#!/bin/sh
# Build the L2 TLB testbench with Verilator and run it.
# Exit status is nonzero when the build fails or the simulation fails.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_l2tlb -f sim.f -o sim_l2tlb \
  && ./obj_dir/sim_l2tlb \
  || { echo "simulation failed"; exit 1; }
